// ==== common/router_ingress_pkg.sv ====
//////////////////////////////
// Beat, metadata and bus structs
// Admission and arbiter state enums
//////////////////////////////

`include "router_ingress_settings.svh"

package router_ingress_pkg;

    // One beat as delivered by a physical port
    typedef struct packed {
        logic [`ING_DATA_BYTES*8-1:0] data;
        logic [`ING_DATA_BYTES-1:0]   keep;
        logic                         last;
    } ing_beat_t;

    // Sideband carried with every beat of the converged bus
    typedef struct packed {
        logic [$clog2(`ING_NUM_PORTS)-1:0] ingress_port;
    } ing_meta_t;

    typedef struct packed {
        ing_meta_t meta;
        ing_beat_t beat;
    } ing_bus_beat_t;

    // Fate of the packet currently arriving at a buffer
    typedef enum logic [1:0] {
        ADM_IDLE,
        ADM_STORE,
        ADM_DROP
    } adm_state_e;

    typedef enum logic {
        ARB_SELECT,
        ARB_PASS
    } arb_state_e;

endpackage

// ==== common/router_ingress_settings.svh ====
//////////////////////////////
// Ingress widths, depths and sizes
//////////////////////////////

`ifndef ROUTER_INGRESS_SETTINGS_SVH
`define ROUTER_INGRESS_SETTINGS_SVH

// Physical ingress ports
`define ING_NUM_PORTS 4

// Bytes carried per beat on ports and on the converged bus
`define ING_DATA_BYTES 4

// Per-port packet buffer depth in beats
`define ING_BUF_WORDS 32

// Largest legal packet in beats, used for admission headroom
`define ING_MAX_PKT_WORDS 16

// Admitted-packet counter width
`define ING_CNT_WIDTH 16

`endif

// ==== port_buffer/port_packet_buffer.sv ====
//////////////////////////////
// Per-port admission FSM and circular beat store
//////////////////////////////

`timescale 1ns/100ps
`include "router_ingress_settings.svh"

module port_packet_buffer (
    input  logic                          core_clk_ifc,
    input  logic                          packet_sink_reset,
    input  logic                          port_valid,
    input  router_ingress_pkg::ing_beat_t port_beat,
    input  logic                          port_enable,
    output logic                          buf_valid,
    output router_ingress_pkg::ing_beat_t buf_beat,
    input  logic                          buf_ready,
    output logic                          admit,
    output logic                          buf_overflow
);

    localparam int PTR_BITS = $clog2(`ING_BUF_WORDS);
    localparam int CNT_BITS = $clog2(`ING_BUF_WORDS + 1);

    router_ingress_pkg::adm_state_e adm_state;
    router_ingress_pkg::ing_beat_t  beat_store [`ING_BUF_WORDS];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] word_count;
    logic [CNT_BITS-1:0] free_words;
    logic                first_beat;
    logic                has_room;
    logic                wr_en;
    logic                rd_en;

    //////////////////////////////
    // Admission decision

    assign free_words = CNT_BITS'(`ING_BUF_WORDS) - word_count;
    assign has_room   = free_words >= CNT_BITS'(`ING_MAX_PKT_WORDS);
    assign first_beat = port_valid && (adm_state == router_ingress_pkg::ADM_IDLE);

    // A packet is either stored whole or dropped whole
    assign wr_en = port_valid &&
                   ((adm_state == router_ingress_pkg::ADM_STORE) ||
                    (first_beat && port_enable && has_room));

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            adm_state    <= router_ingress_pkg::ADM_IDLE;
            admit        <= 1'b0;
            buf_overflow <= 1'b0;
        end else begin
            admit        <= wr_en && port_beat.last;
            // Only a lack of space counts as overflow, not a disabled port
            buf_overflow <= first_beat && port_enable && !has_room;
            if (port_valid) begin
                if (port_beat.last) begin
                    adm_state <= router_ingress_pkg::ADM_IDLE;
                end else if (first_beat) begin
                    adm_state <= wr_en ? router_ingress_pkg::ADM_STORE
                                       : router_ingress_pkg::ADM_DROP;
                end
            end
        end
    end

    //////////////////////////////
    // Beat store

    assign buf_valid = (word_count != '0);
    assign buf_beat  = beat_store[rd_ptr];
    assign rd_en     = buf_valid && buf_ready;

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            beat_store[wr_ptr] <= port_beat;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            word_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(`ING_BUF_WORDS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(`ING_BUF_WORDS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   word_count <= word_count + 1'b1;
                2'b01:   word_count <= word_count - 1'b1;
                default: word_count <= word_count;
            endcase
        end
    end

    // Headroom checked at the first beat must cover the rest of the packet
    a_no_write_when_full: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        wr_en |-> (word_count < CNT_BITS'(`ING_BUF_WORDS))
    );

endmodule

// ==== router_ingress.f ====
+incdir+common
common/router_ingress_pkg.sv
port_buffer/port_packet_buffer.sv
src/ingress_counter_bank.sv
src/ingress_arbiter.sv
src/router_ingress.sv
testbench/core_clock_gen.sv
testbench/router_ingress_tb.sv

// ==== src/ingress_arbiter.sv ====
//////////////////////////////
// Packet round-robin arbiter
// Ingress port metadata insertion
//////////////////////////////

`timescale 1ns/100ps
`include "router_ingress_settings.svh"

module ingress_arbiter (
    input  logic                              core_clk_ifc,
    input  logic                              packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0]         buf_valid,
    input  router_ingress_pkg::ing_beat_t     buf_beat [`ING_NUM_PORTS-1:0],
    output logic [`ING_NUM_PORTS-1:0]         buf_ready,
    output logic                              out_valid,
    output router_ingress_pkg::ing_bus_beat_t out_beat,
    input  logic                              out_ready
);

    localparam int PORT_BITS = $bits(router_ingress_pkg::ing_meta_t);

    router_ingress_pkg::arb_state_e arb_state;

    logic [PORT_BITS-1:0] grant_port;
    logic [PORT_BITS-1:0] last_port;
    logic [PORT_BITS-1:0] pick_port;
    logic                 pick_found;
    logic                 passing;
    logic                 pkt_done;

    //////////////////////////////
    // Next port after the last one served

    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_port  = last_port;
        for (int off = 1; off <= `ING_NUM_PORTS; off++) begin
            idx = (int'(last_port) + off) % `ING_NUM_PORTS;
            if (!pick_found && buf_valid[idx]) begin
                pick_found = 1'b1;
                pick_port  = PORT_BITS'(idx);
            end
        end
    end

    //////////////////////////////
    // Beat forwarding

    assign passing  = (arb_state == router_ingress_pkg::ARB_PASS);
    assign out_valid = passing && buf_valid[grant_port];
    assign pkt_done  = out_valid && out_ready && out_beat.beat.last;

    always_comb begin
        out_beat.meta.ingress_port = grant_port;
        out_beat.beat              = buf_beat[grant_port];
    end

    // Only the granted buffer sees the sink's ready
    always_comb begin
        buf_ready = '0;
        buf_ready[grant_port] = passing && out_ready;
    end

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            arb_state  <= router_ingress_pkg::ARB_SELECT;
            grant_port <= '0;
            last_port  <= PORT_BITS'(`ING_NUM_PORTS - 1);
        end else begin
            case (arb_state)
                router_ingress_pkg::ARB_SELECT: begin
                    if (pick_found) begin
                        grant_port <= pick_port;
                        arb_state  <= router_ingress_pkg::ARB_PASS;
                    end
                end
                router_ingress_pkg::ARB_PASS: begin
                    // Grant holds until the last beat is handed over
                    if (pkt_done) begin
                        last_port <= grant_port;
                        arb_state <= router_ingress_pkg::ARB_SELECT;
                    end
                end
                default: arb_state <= router_ingress_pkg::ARB_SELECT;
            endcase
        end
    end

    //////////////////////////////
    // Checks

    a_hold_while_stalled: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    );

    a_single_ready: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        $onehot0(buf_ready)
    );

endmodule

// ==== src/ingress_counter_bank.sv ====
//////////////////////////////
// Admitted-packet counters
//////////////////////////////

`timescale 1ns/100ps
`include "router_ingress_settings.svh"

module ingress_counter_bank (
    input  logic                      core_clk_ifc,
    input  logic                      packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0] admit,
    input  logic [`ING_NUM_PORTS-1:0] ing_cnts_clear,
    output logic [`ING_CNT_WIDTH-1:0] ing_cnts [`ING_NUM_PORTS-1:0]
);

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            for (int i = 0; i < `ING_NUM_PORTS; i++) begin
                ing_cnts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `ING_NUM_PORTS; i++) begin
                // Clear beats a coincident admit
                if (ing_cnts_clear[i]) begin
                    ing_cnts[i] <= '0;
                end else if (admit[i] && (ing_cnts[i] != '1)) begin
                    // Saturate instead of wrapping
                    ing_cnts[i] <= ing_cnts[i] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/router_ingress.sv ====
//////////////////////////////
// Ingress stage top level
//////////////////////////////

`timescale 1ns/100ps
`include "router_ingress_settings.svh"

module router_ingress (
    input  logic                              core_clk_ifc,
    input  logic                              packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0]         port_valid,
    input  router_ingress_pkg::ing_beat_t     port_beat [`ING_NUM_PORTS-1:0],
    input  logic [`ING_NUM_PORTS-1:0]         ing_phys_ports_enable,
    input  logic [`ING_NUM_PORTS-1:0]         ing_cnts_clear,
    output logic                              out_valid,
    output router_ingress_pkg::ing_bus_beat_t out_beat,
    input  logic                              out_ready,
    output logic [`ING_CNT_WIDTH-1:0]         ing_cnts [`ING_NUM_PORTS-1:0],
    output logic [`ING_NUM_PORTS-1:0]         ing_buf_overflow
);

    logic [`ING_NUM_PORTS-1:0]     buf_valid;
    logic [`ING_NUM_PORTS-1:0]     buf_ready;
    logic [`ING_NUM_PORTS-1:0]     admit;
    router_ingress_pkg::ing_beat_t buf_beat [`ING_NUM_PORTS-1:0];

    // One packet buffer per physical port
    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : g_port
        port_packet_buffer u_port_packet_buffer (
            .core_clk_ifc      (core_clk_ifc),
            .packet_sink_reset (packet_sink_reset),
            .port_valid        (port_valid[p]),
            .port_beat         (port_beat[p]),
            .port_enable       (ing_phys_ports_enable[p]),
            .buf_valid         (buf_valid[p]),
            .buf_beat          (buf_beat[p]),
            .buf_ready         (buf_ready[p]),
            .admit             (admit[p]),
            .buf_overflow      (ing_buf_overflow[p])
        );
    end

    ingress_counter_bank u_ingress_counter_bank (
        .core_clk_ifc      (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset),
        .admit             (admit),
        .ing_cnts_clear    (ing_cnts_clear),
        .ing_cnts          (ing_cnts)
    );

    ingress_arbiter u_ingress_arbiter (
        .core_clk_ifc      (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset),
        .buf_valid         (buf_valid),
        .buf_beat          (buf_beat),
        .buf_ready         (buf_ready),
        .out_valid         (out_valid),
        .out_beat          (out_beat),
        .out_ready         (out_ready)
    );

endmodule

// ==== testbench/core_clock_gen.sv ====
//////////////////////////////
// 20 ns clock and 5-cycle reset
//////////////////////////////

`timescale 1ns/100ps

module core_clock_gen (
    output logic core_clk_ifc,
    output logic packet_sink_reset
);

    initial begin
        core_clk_ifc = 1'b0;
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    initial begin
        packet_sink_reset = 1'b1;
        repeat (5) @(posedge core_clk_ifc);
        #2;
        packet_sink_reset = 1'b0;
    end

endmodule

// ==== testbench/router_ingress_tb.sv ====
//////////////////////////////
// Ingress stage testbench
// Stimulus, reference model, assertions and timeout
//////////////////////////////

`timescale 1ns/100ps
`include "router_ingress_settings.svh"

module router_ingress_tb;

    localparam int NP             = `ING_NUM_PORTS;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DRAIN_CYCLES   = 600;

    logic                              core_clk_ifc;
    logic                              packet_sink_reset;
    logic [NP-1:0]                     port_valid;
    router_ingress_pkg::ing_beat_t     port_beat [NP-1:0];
    logic [NP-1:0]                     ing_phys_ports_enable;
    logic [NP-1:0]                     ing_cnts_clear;
    logic                              out_valid;
    router_ingress_pkg::ing_bus_beat_t out_beat;
    logic                              out_ready;
    logic [`ING_CNT_WIDTH-1:0]         ing_cnts [NP-1:0];
    logic [NP-1:0]                     ing_buf_overflow;

    // Reference model with expected beats per port, occupancy and counts
    router_ingress_pkg::ing_beat_t exp_q [NP][$];
    router_ingress_pkg::ing_beat_t exp_beat;
    logic                          exp_known;
    logic [NP-1:0]                 exp_overflow;
    int rem [NP];
    bit at_first [NP];
    bit keep_pkt [NP];
    int occ [NP];
    int exp_cnt [NP];
    int drops [NP];
    int pending;
    int start_odds;
    int ready_mode;
    bit gen_on;
    bit toggle_on;
    bit check_drained;
    bit check_counts;
    int cycle_count = 0;

    core_clock_gen u_core_clock_gen (
        .core_clk_ifc      (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset)
    );

    router_ingress u_router_ingress (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        abort_run($sformatf("error at %0t ns: %s expected %h actual %h", $time, name, exp, act));
    endtask

    //////////////////////////////
    // Stimulus and admission model

    task automatic step_ports();
        router_ingress_pkg::ing_beat_t b;
        for (int p = 0; p < NP; p++) begin
            port_valid[p]   = 1'b0;
            exp_overflow[p] = 1'b0;
            if (toggle_on && $urandom_range(0, 63) == 0) begin
                ing_phys_ports_enable[p] = !ing_phys_ports_enable[p];
            end
            if (rem[p] == 0 && gen_on && $urandom_range(0, start_odds) == 0) begin
                rem[p]      = $urandom_range(1, `ING_MAX_PKT_WORDS);
                at_first[p] = 1'b1;
            end
            if (rem[p] != 0 && $urandom_range(0, 3) != 0) begin
                // Whole packet fate fixed at its first beat
                if (at_first[p]) begin
                    keep_pkt[p] = ing_phys_ports_enable[p] &&
                                  (`ING_BUF_WORDS - occ[p] >= `ING_MAX_PKT_WORDS);
                    exp_overflow[p] = ing_phys_ports_enable[p] && !keep_pkt[p];
                    drops[p] += int'(exp_overflow[p]);
                    at_first[p] = 1'b0;
                end
                rem[p]--;
                b.data = $urandom();
                b.keep = $urandom_range(1, (1 << `ING_DATA_BYTES) - 1);
                b.last = (rem[p] == 0);
                port_beat[p]  = b;
                port_valid[p] = 1'b1;
                if (keep_pkt[p]) begin
                    exp_q[p].push_back(b);
                    occ[p]++;
                    pending++;
                    exp_cnt[p] += int'(b.last);
                end
            end
        end
        out_ready = (ready_mode == 2) ? ($urandom_range(0, 3) != 0) : (ready_mode == 1);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge core_clk_ifc);
            #2;
            step_ports();
        end
    endtask

    function automatic bit ports_quiet();
        bit q;
        q = (pending == 0);
        for (int p = 0; p < NP; p++) q &= (rem[p] == 0);
        return q;
    endfunction

    function automatic int fewest_drops();
        int m;
        m = drops[0];
        for (int p = 1; p < NP; p++) m = (drops[p] < m) ? drops[p] : m;
        return m;
    endfunction

    // Finish packets in flight and let the sink take everything
    task automatic drain_and_check();
        int n;
        gen_on     = 1'b0;
        ready_mode = 1;
        n = 0;
        while (!ports_quiet() && n < DRAIN_CYCLES) begin
            run_cycles(1);
            n++;
        end
        check_drained = 1'b1;
        run_cycles(1);
        check_drained = 1'b0;
    endtask

    // Output side of the model sampled at the falling edge where the bus is stable
    always @(negedge core_clk_ifc) begin
        int p;
        exp_known = 1'b0;
        p = int'(out_beat.meta.ingress_port);
        if (!packet_sink_reset && out_valid && exp_q[p].size() != 0) begin
            exp_known = 1'b1;
            exp_beat  = exp_q[p][0];
            if (out_ready) begin
                void'(exp_q[p].pop_front());
                occ[p]--;
                pending--;
            end
        end
    end

    always @(posedge core_clk_ifc) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    //////////////////////////////
    // Checks

    a_port_in_range: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        out_valid |-> (int'(out_beat.meta.ingress_port) < NP)
    ) else abort_run("output beat names an ingress port that does not exist");

    a_known_packet: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        out_valid |-> exp_known
    ) else abort_run("output beat with no admitted packet pending on its port");

    a_beat_match: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        (out_valid && exp_known) |-> (out_beat.beat == exp_beat)
    ) else report_mismatch("out_beat.beat", $sampled(exp_beat), $sampled(out_beat.beat));

    a_hold_stalled: assert property (
        @(posedge core_clk_ifc) disable iff (packet_sink_reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else abort_run("out_valid or out_beat changed while the sink stalled");

    a_all_delivered: assert property (
        @(posedge core_clk_ifc) check_drained |-> (pending == 0)
    ) else abort_run("admitted beats still missing at the output after the drain");

    for (genvar g = 0; g < NP; g++) begin : g_port_checks
        a_overflow_pulse: assert property (
            @(posedge core_clk_ifc) disable iff (packet_sink_reset)
            exp_overflow[g] |=> ing_buf_overflow[g]
        ) else report_mismatch($sformatf("ing_buf_overflow[%0d]", g), 1, 0);

        a_overflow_quiet: assert property (
            @(posedge core_clk_ifc) disable iff (packet_sink_reset)
            !exp_overflow[g] |=> !ing_buf_overflow[g]
        ) else report_mismatch($sformatf("ing_buf_overflow[%0d]", g), 0, 1);

        a_count: assert property (
            @(posedge core_clk_ifc) check_counts |-> (ing_cnts[g] == exp_cnt[g])
        ) else report_mismatch($sformatf("ing_cnts[%0d]", g), $sampled(exp_cnt[g]),
                               $sampled(ing_cnts[g]));
    end

    initial begin
        void'($urandom(32'h23e1));
        port_valid   = '0;
        exp_overflow = '0;
        for (int p = 0; p < NP; p++) begin
            port_beat[p] = '0;
        end
        ing_phys_ports_enable    = '1;
        ing_phys_ports_enable[2] = 1'b0;
        ing_cnts_clear = '0;
        out_ready      = 1'b0;
        @(negedge packet_sink_reset);

        // Random traffic with sink stalls and enables flipping at any time
        start_odds = 31;
        ready_mode = 2;
        gen_on     = 1'b1;
        toggle_on  = 1'b1;
        run_cycles(9000);
        toggle_on = 1'b0;
        drain_and_check();

        // Sink held off until every buffer has dropped packets for lack of space
        ing_phys_ports_enable = '1;
        drops      = '{default: 0};
        start_odds = 1;
        ready_mode = 0;
        gen_on     = 1'b1;
        while (fewest_drops() < 2) begin
            run_cycles(1);
        end
        drain_and_check();

        // Counts after traffic and after a clear of port 1 only
        run_cycles(4);
        check_counts = 1'b1;
        run_cycles(4);
        check_counts      = 1'b0;
        ing_cnts_clear[1] = 1'b1;
        run_cycles(1);
        ing_cnts_clear[1] = 1'b0;
        exp_cnt[1]        = 0;
        check_counts      = 1'b1;
        run_cycles(4);
        $display("TEST PASS");
        $finish;
    end

endmodule
